/* Makefile */
# Verilator build and run for the seed unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_fp_seed_unit
FILELIST  ?= fp_seed_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
SIM_ARGS  ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv tb/*.sv include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* fp_seed_unit.f */
+incdir+include
src/fp_fmt_pkg.sv
src/seed_op_pkg.sv
src/seed_if.sv
src/seed_ctrl_fsm.sv
src/table_clear_counter.sv
src/seed_index_gen.sv
src/seed_table.sv
src/frac_trunc_unit.sv
src/fp_seed_unit.sv
tb/fp_seed_unit_asserts.sv
tb/tb_fp_seed_unit.sv

/* include/fp_seed_consts.svh */
`ifndef FP_SEED_CONSTS_SVH
`define FP_SEED_CONSTS_SVH

// Register word layout.
`define FP_WORD_W 68

// Seed table geometry.
`define SEED_DEPTH 320
`define SEED_HI_BASE 256

// Biased exponent keys where the windows open.
`define LO_WIN_BASE 2040
`define HI_WIN_BASE 2044

`endif

/* src/fp_fmt_pkg.sv */
`default_nettype none

package fp_fmt_pkg;

  // Tag in 67:66, exponent in 65:53, mantissa in 52:0.
  typedef struct packed {
    logic [1:0]  tag;
    logic [12:0] exp;
    logic [52:0] mant;
  } fp_word_t;

  // Table address, wide enough for 320 entries.
  typedef logic [8:0] seed_addr_t;

  // Upper 12 exponent bits, word bits 65:54.
  typedef logic [11:0] exp_key_t;

endpackage

`default_nettype wire

/* src/fp_seed_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_seed_unit (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     start,
  input  seed_op_pkg::seed_op_e   op,
  input  fp_fmt_pkg::fp_word_t    operand,
  input  wire                     wr_en,
  input  fp_fmt_pkg::seed_addr_t  wr_addr,
  input  fp_fmt_pkg::fp_word_t    wr_data,
  output logic                    ready,
  output logic                    busy,
  output logic                    done,
  output fp_fmt_pkg::fp_word_t    result
);
  import fp_fmt_pkg::*;

  logic       clearing;
  seed_addr_t clear_addr;
  seed_addr_t rd_addr;
  fp_word_t   rd_data;

  seed_if sif ();

  seed_ctrl_fsm u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .op      (op),
    .operand (operand),
    .ready   (ready),
    .busy    (busy),
    .done    (done),
    .sif     (sif.ctrl)
  );

  table_clear_counter u_clear (
    .clk        (clk),
    .rst_n      (rst_n),
    .clearing   (clearing),
    .clear_addr (clear_addr),
    .ready      (ready)
  );

  seed_index_gen u_index (
    .sif     (sif.index),
    .rd_addr (rd_addr)
  );

  seed_table u_table (
    .clk        (clk),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .clearing   (clearing),
    .clear_addr (clear_addr),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  frac_trunc_unit u_result (
    .clk     (clk),
    .rst_n   (rst_n),
    .sif     (sif.result),
    .rd_data (rd_data),
    .result  (result)
  );

endmodule

`default_nettype wire

/* src/frac_trunc_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fp_seed_consts.svh"

module frac_trunc_unit (
  input  wire                   clk,
  input  wire                   rst_n,
  seed_if.result                sif,
  input  fp_fmt_pkg::fp_word_t  rd_data,
  output fp_fmt_pkg::fp_word_t  result
);
  import fp_fmt_pkg::*;
  import seed_op_pkg::*;

  exp_key_t    key;
  exp_key_t    base;
  exp_key_t    k;
  logic [52:0] keep;
  fp_word_t    trunc;

  assign key  = sif.operand.exp[12:1];
  assign base = (sif.op == OP_TRUNC_HI) ? exp_key_t'(`HI_WIN_BASE) : exp_key_t'(`LO_WIN_BASE);
  assign k    = key - base;

  always_comb begin
    if (key <= base) keep = '0;  // No integer bits.
    else if (k >= 12'd7) keep = '1;
    else keep = ~({53{1'b1}} >> k[2:0]);  // Top k bits survive.
  end

  assign trunc = '{tag: sif.operand.tag, exp: sif.operand.exp, mant: sif.operand.mant & keep};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
    end else if (sif.finish) begin
      case (sif.op)
        OP_SEED_LO, OP_SEED_ODD, OP_SEED_HI: result <= rd_data;
        OP_TRUNC_LO, OP_TRUNC_HI:            result <= trunc;
        default:                             result <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/seed_ctrl_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module seed_ctrl_fsm (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    start,
  input  seed_op_pkg::seed_op_e  op,
  input  fp_fmt_pkg::fp_word_t   operand,
  input  wire                    ready,
  output logic                   busy,
  output logic                   done,
  seed_if.ctrl                   sif
);
  import seed_op_pkg::*;

  ctrl_state_e state;
  logic        accept;

  assign accept = start && ready && !busy;

  assign sif.launch = (state == ST_READ);
  assign sif.finish = (state == ST_DONE);
  assign busy       = sif.launch || sif.finish;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_CLEAR;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_CLEAR: begin
          // A start in the cycle ready rises is not lost.
          if (accept) state <= ST_READ;
          else if (ready) state <= ST_IDLE;
        end
        ST_IDLE:  if (accept) state <= ST_READ;
        ST_READ:  state <= ST_DONE;
        ST_DONE: begin
          state <= ST_IDLE;
          done  <= 1'b1;
        end
        default:  state <= ST_CLEAR;
      endcase
    end
  end

  // Operation payload, held until the next accepted start.
  always_ff @(posedge clk) begin
    if (accept) begin
      sif.op      <= op;
      sif.operand <= operand;
    end
  end

endmodule

`default_nettype wire

/* src/seed_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface seed_if;
  import fp_fmt_pkg::*;
  import seed_op_pkg::*;

  seed_op_e op;      // Operation in flight.
  fp_word_t operand;
  logic     launch;  // Address phase.
  logic     finish;  // Result phase.

  modport ctrl (
    output op, operand, launch, finish
  );

  modport index (
    input op, operand, launch
  );

  modport result (
    input op, operand, finish
  );

endinterface

`default_nettype wire

/* src/seed_index_gen.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fp_seed_consts.svh"

module seed_index_gen (
  seed_if.index                   sif,
  output fp_fmt_pkg::seed_addr_t  rd_addr
);
  import fp_fmt_pkg::*;
  import seed_op_pkg::*;

  exp_key_t   key;
  exp_key_t   base;
  exp_key_t   k;
  logic [5:0] idx;

  assign key  = sif.operand.exp[12:1];
  assign base = (sif.op == OP_SEED_HI) ? exp_key_t'(`HI_WIN_BASE) : exp_key_t'(`LO_WIN_BASE);
  assign k    = key - base;  // Below the base wraps to a large value.

  always_comb begin
    idx = 6'd0;
    if (k >= 12'd1 && k <= 12'd6) begin
      // Leading one, then k-1 mantissa bits right-aligned.
      idx = {1'b1, 5'(sif.operand.mant[52:48] >> (3'd6 - k[2:0]))};
    end
  end

  always_comb begin
    rd_addr = '0;
    if (sif.launch) begin
      case (sif.op)
        OP_SEED_LO:  rd_addr = {1'b0, idx, 2'b00};
        OP_SEED_ODD: rd_addr = {1'b0, idx, 2'b01};  // Fixed odd slot.
        OP_SEED_HI:  rd_addr = seed_addr_t'(`SEED_HI_BASE) + seed_addr_t'(idx);
        default:     rd_addr = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/seed_op_pkg.sv */
`default_nettype none

package seed_op_pkg;

  typedef enum logic [2:0] {
    OP_SEED_LO  = 3'd0,
    OP_SEED_ODD = 3'd1,
    OP_SEED_HI  = 3'd2,
    OP_TRUNC_LO = 3'd5,
    OP_TRUNC_HI = 3'd6
  } seed_op_e;

  typedef enum logic [1:0] {
    ST_CLEAR,
    ST_IDLE,
    ST_READ,
    ST_DONE
  } ctrl_state_e;

endpackage

`default_nettype wire

/* src/seed_table.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fp_seed_consts.svh"

module seed_table (
  input  wire                     clk,
  input  wire                     wr_en,
  input  fp_fmt_pkg::seed_addr_t  wr_addr,
  input  fp_fmt_pkg::fp_word_t    wr_data,
  input  wire                     clearing,
  input  fp_fmt_pkg::seed_addr_t  clear_addr,
  input  fp_fmt_pkg::seed_addr_t  rd_addr,
  output fp_fmt_pkg::fp_word_t    rd_data
);
  import fp_fmt_pkg::*;

  logic [`FP_WORD_W-1:0] mem [`SEED_DEPTH];

  // Clear walk owns the write port until it finishes.
  always_ff @(posedge clk) begin
    if (clearing) begin
      mem[clear_addr] <= '0;
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Same-cycle write is not forwarded.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* src/table_clear_counter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fp_seed_consts.svh"

module table_clear_counter (
  input  wire                     clk,
  input  wire                     rst_n,
  output logic                    clearing,
  output fp_fmt_pkg::seed_addr_t  clear_addr,
  output logic                    ready
);
  import fp_fmt_pkg::*;

  seed_addr_t cnt;

  assign clear_addr = cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt      <= '0;
      clearing <= 1'b1;
      ready    <= 1'b0;
    end else if (clearing) begin
      if (cnt == seed_addr_t'(`SEED_DEPTH - 1)) begin
        clearing <= 1'b0;  // Last entry written this cycle.
        ready    <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/fp_seed_unit_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_seed_unit_asserts (
  input wire       clk,
  input wire       rst_n,
  input wire       start,
  input wire [2:0] op,
  input wire       ready,
  input wire       busy,
  input wire       done
);
  logic accept;

  assign accept = start && ready && !busy;

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // Registered at the second edge after acceptance, so sampled on the third.
  done_latency: assert property (@(posedge clk) disable iff (!rst_n) done == $past(accept, 3))
    else $error("done did not follow an accepted start by two cycles");

  done_needs_ready: assert property (@(posedge clk) disable iff (!rst_n) $rose(done) |-> ready)
    else $error("done rose while ready was low");

  legal_op: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> (op <= 3'd2 || op == 3'd5 || op == 3'd6))
    else $error("illegal opcode accepted with start");

endmodule

`default_nettype wire

/* tb/tb_fp_seed_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fp_seed_consts.svh"

module tb_fp_seed_unit;
  import fp_fmt_pkg::*;
  import seed_op_pkg::*;

  localparam int CLEAR_TIMEOUT = 400;
  localparam int DONE_TIMEOUT  = 16;

  logic       clk;
  logic       rst_n;
  logic       start;
  seed_op_e   op;
  fp_word_t   operand;
  logic       wr_en;
  seed_addr_t wr_addr;
  fp_word_t   wr_data;
  logic       ready;
  logic       busy;
  logic       done;
  fp_word_t   result;

  integer     seed;
  fp_word_t   model_mem [`SEED_DEPTH];  // Reference copy of the seed table.

  fp_seed_unit u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .op      (op),
    .operand (operand),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .ready   (ready),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  bind fp_seed_unit fp_seed_unit_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .op    (op),
    .ready (ready),
    .busy  (busy),
    .done  (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first failed check.");
  endtask

  task automatic check_val(input string name, input logic [67:0] exp, input logic [67:0] act);
    assert (act === exp) else
      fail_run($sformatf("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act));
  endtask

  function automatic fp_word_t rand_word();
    logic [95:0] raw;
    raw = {$random(seed), $random(seed), $random(seed)};
    return raw[67:0];
  endfunction

  function automatic seed_addr_t rand_addr();
    return seed_addr_t'($unsigned($random(seed)) % `SEED_DEPTH);
  endfunction

  function automatic int win_base(input seed_op_e op_i);
    return (op_i == OP_SEED_HI || op_i == OP_TRUNC_HI) ? `HI_WIN_BASE : `LO_WIN_BASE;
  endfunction

  // Keys from three below the base to nine above it.
  function automatic logic [11:0] pick_key(input int base);
    return 12'(base - 3 + int'($unsigned($random(seed)) % 13));
  endfunction

  function automatic fp_word_t make_operand(input logic [11:0] key);
    fp_word_t w;
    w = rand_word();
    w[65:54] = key;
    return w;
  endfunction

  function automatic int seed_addr(input seed_op_e op_i, input fp_word_t opnd);
    int k;
    int idx;
    k = int'(opnd[65:54]) - win_base(op_i);
    idx = 0;
    if (k >= 1 && k <= 6) begin
      idx = 32;  // Leading one.
      for (int j = 0; j < k - 1; j++) idx += int'(opnd[52 - j]) << (k - 2 - j);
    end
    case (op_i)
      OP_SEED_LO:  return idx * 4;
      OP_SEED_ODD: return idx * 4 + 1;
      default:     return `SEED_HI_BASE + idx;
    endcase
  endfunction

  function automatic fp_word_t trunc_model(input seed_op_e op_i, input fp_word_t opnd);
    fp_word_t w;
    int k;
    w = opnd;
    k = int'(opnd[65:54]) - win_base(op_i);
    if (k <= 0) begin
      w[52:0] = '0;
    end else if (k <= 6) begin
      for (int b = 0; b <= 52 - k; b++) w[b] = 1'b0;
    end
    return w;
  endfunction

  task automatic host_write(input seed_addr_t addr, input fp_word_t data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk);
    #1;
    wr_en = 1'b0;
    model_mem[addr] = data;
  endtask

  // Mode 1 pokes start while busy, mode 2 writes the read address in the table read cycle.
  task automatic run_op(input seed_op_e op_i, input fp_word_t opnd, input int mode);
    fp_word_t exp_val;
    fp_word_t other;
    int       cycles;
    other = rand_word();
    if (op_i == OP_TRUNC_LO || op_i == OP_TRUNC_HI) exp_val = trunc_model(op_i, opnd);
    else exp_val = model_mem[seed_addr(op_i, opnd)];
    start   = 1'b1;
    op      = op_i;
    operand = opnd;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (mode == 1) begin
      start   = 1'b1;
      op      = OP_TRUNC_HI;
      operand = other;
    end else if (mode == 2) begin
      wr_en   = 1'b1;
      wr_addr = seed_addr_t'(seed_addr(op_i, opnd));
      wr_data = other;
    end
    cycles = 0;
    while (!done) begin
      assert (busy) else fail_run("busy dropped before done arrived");
      @(posedge clk);
      #1;
      start = 1'b0;
      wr_en = 1'b0;
      cycles++;
      assert (cycles <= DONE_TIMEOUT) else fail_run("Timeout waiting for done after start");
    end
    if (mode == 2) model_mem[seed_addr(op_i, opnd)] = other;
    assert (cycles == 2) else
      fail_run($sformatf("ERROR at %0t ns: done latency expected 2, got %0d", $time, cycles));
    check_val("result", exp_val, result);
    if (mode == 1) begin
      repeat (3) begin
        @(posedge clk);
        #1;
        assert (!done && !busy) else fail_run("start issued while busy launched an operation");
        check_val("result", exp_val, result);
      end
    end
  endtask

  initial begin
    int       cycles;
    int       offs [5];
    seed_op_e seed_ops [3];
    seed_op_e trunc_ops [2];
    fp_word_t opnd;
    seed     = 32'h8b12;
    offs     = '{0, 1, 6, 7, -1};
    seed_ops = '{OP_SEED_LO, OP_SEED_ODD, OP_SEED_HI};
    trunc_ops = '{OP_TRUNC_LO, OP_TRUNC_HI};
    rst_n   = 1'b0;
    start   = 1'b0;
    op      = OP_SEED_LO;
    operand = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    for (int a = 0; a < `SEED_DEPTH; a++) model_mem[a] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    cycles = 0;
    while (!ready) begin
      assert (!busy && !done) else fail_run("busy or done went high during the table clear");
      check_val("result", '0, result);
      // Host writes and starts are ignored until ready.
      start   = 1'b1;
      wr_en   = 1'b1;
      wr_addr = rand_addr();
      wr_data = rand_word();
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles <= CLEAR_TIMEOUT) else fail_run("Timeout waiting for ready after reset");
    end
    start = 1'b0;
    wr_en = 1'b0;
    assert (cycles == `SEED_DEPTH) else
      fail_run($sformatf("ERROR at %0t ns: clear cycles expected %0d, got %0d",
                         $time, `SEED_DEPTH, cycles));
    run_op(OP_SEED_ODD, make_operand(12'(`LO_WIN_BASE + 3)), 0);

    repeat (200) host_write(rand_addr(), rand_word());
    for (int i = 0; i < 150; i++) begin
      run_op(seed_ops[i % 3], make_operand(pick_key(win_base(seed_ops[i % 3]))), 0);
    end

    // Window edges of every seed opcode.
    foreach (seed_ops[s]) begin
      foreach (offs[j]) run_op(seed_ops[s], make_operand(12'(win_base(seed_ops[s]) + offs[j])), 0);
    end

    foreach (trunc_ops[t]) begin
      for (int k = -3; k <= 10; k++) begin
        repeat (2) run_op(trunc_ops[t], make_operand(12'(win_base(trunc_ops[t]) + k)), 0);
      end
    end

    run_op(OP_SEED_HI, make_operand(12'(`HI_WIN_BASE + 4)), 1);
    run_op(OP_TRUNC_LO, make_operand(12'(`LO_WIN_BASE + 3)), 1);

    opnd = make_operand(12'(`HI_WIN_BASE + 5));
    run_op(OP_SEED_HI, opnd, 2);
    run_op(OP_SEED_HI, opnd, 0);
    opnd = make_operand(12'(`LO_WIN_BASE + 6));
    run_op(OP_SEED_LO, opnd, 2);
    run_op(OP_SEED_LO, opnd, 0);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
